// ==== logic/bp_pkg.sv ====
// Branch predictor package with the slot count, index geometry and counter encoding

package bp_pkg;

	// ==================================================
	// Machine width
	// ==================================================

	// Number of commit slots and of fetch lookup ports
	localparam int NUM_SLOTS = 4;

	// ==================================================
	// Index geometry
	// ==================================================

	// Lowest instruction-address bit that takes part in the table index
	localparam int PC_LO = 3;

	// Number of address bits in the index, bits 9:3 of the address
	localparam int PC_IDX_W = 7;

	// ==================================================
	// Saturating counter
	// ==================================================

	// Two-bit counter, 0 and 1 predict not taken, 2 and 3 predict taken
	typedef logic [1:0] ctr_t;

	// Every counter comes out of reset weakly not taken
	localparam ctr_t CTR_INIT = 2'd1;

	// Smallest counter value that gives a taken prediction
	localparam ctr_t CTR_TAKEN_MIN = 2'd2;

endpackage

// ==== logic/branch_update_queue.sv ====
// Commit-side update queue that packs up to four resolved branches per cycle and drains one

`timescale 1ns/10ps

module branch_update_queue import bp_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int QUEUE_DEPTH = 16
)
(
	input  logic              clk,
	input  logic              rst,
	input  logic              commit_valid0,
	input  logic              commit_valid1,
	input  logic              commit_valid2,
	input  logic              commit_valid3,
	input  logic [ADDR_W-1:0] commit_pc0,
	input  logic [ADDR_W-1:0] commit_pc1,
	input  logic [ADDR_W-1:0] commit_pc2,
	input  logic [ADDR_W-1:0] commit_pc3,
	input  logic              commit_taken0,
	input  logic              commit_taken1,
	input  logic              commit_taken2,
	input  logic              commit_taken3,
	output logic              commit_ready,
	output logic              upd_valid,
	output logic [ADDR_W-1:0] upd_pc,
	output logic              upd_taken,
	input  logic              upd_ready
);

	// Pointer width follows the depth
	// The count needs one more bit than the pointers to hold a full queue
	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	// Enough bits to count every commit slot at once
	localparam int SLOT_CNT_W = $clog2(NUM_SLOTS + 1);

	// The pointers wrap by plain overflow, so the depth has to be a power of two
	if (QUEUE_DEPTH < 8 || (1 << PTR_W) != QUEUE_DEPTH)
	begin : g_depth_check
		$error("branch_update_queue needs a power-of-two QUEUE_DEPTH of at least 8");
	end

	// ==================================================
	// Commit slots gathered into arrays
	// ==================================================

	logic              slot_valid [NUM_SLOTS];
	logic [ADDR_W-1:0] slot_pc    [NUM_SLOTS];
	logic              slot_taken [NUM_SLOTS];

	assign slot_valid[0] = commit_valid0;
	assign slot_valid[1] = commit_valid1;
	assign slot_valid[2] = commit_valid2;
	assign slot_valid[3] = commit_valid3;

	assign slot_pc[0] = commit_pc0;
	assign slot_pc[1] = commit_pc1;
	assign slot_pc[2] = commit_pc2;
	assign slot_pc[3] = commit_pc3;

	assign slot_taken[0] = commit_taken0;
	assign slot_taken[1] = commit_taken1;
	assign slot_taken[2] = commit_taken2;
	assign slot_taken[3] = commit_taken3;

	// ==================================================
	// Queue state
	// ==================================================

	// Address and outcome of each entry are kept side by side
	logic [ADDR_W-1:0] pc_mem    [QUEUE_DEPTH];
	logic              taken_mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] free_cnt;

	// Per-slot write position behind the tail after the invalid slots are squeezed out
	logic [PTR_W-1:0]      wr_idx   [NUM_SLOTS];
	logic [SLOT_CNT_W-1:0] push_cnt;
	logic [SLOT_CNT_W-1:0] push_n;
	logic                  push_en;
	logic                  pop;

	// The whole group is taken only when room for every slot is guaranteed
	assign free_cnt     = CNT_W'(QUEUE_DEPTH) - count;
	assign commit_ready = free_cnt >= CNT_W'(NUM_SLOTS);
	assign push_en      = commit_ready;

	// ==================================================
	// Slot compaction
	// ==================================================

	// Each valid slot lands after every valid slot with a lower number
	always_comb
	begin
		push_cnt = '0;
		for (int s = 0; s < NUM_SLOTS; s++)
		begin
			wr_idx[s] = tail + PTR_W'(push_cnt);
			if (slot_valid[s])
				push_cnt = push_cnt + 1'b1;
		end
	end

	// Nothing enters while the commit side is stalled
	assign push_n = push_en ? push_cnt : '0;

	// Entries are written at the accepting edge
	always_ff @(posedge clk)
	begin
		for (int s = 0; s < NUM_SLOTS; s++)
		begin
			if (push_en && slot_valid[s])
			begin
				pc_mem[wr_idx[s]]    <= slot_pc[s];
				taken_mem[wr_idx[s]] <= slot_taken[s];
			end
		end
	end

	// ==================================================
	// Drain side
	// ==================================================

	// The oldest entry is always on offer while the queue holds anything
	assign upd_valid = count != '0;
	assign upd_pc    = pc_mem[head];
	assign upd_taken = taken_mem[head];
	assign pop       = upd_valid && upd_ready;

	// Tail moves by the number of accepted slots, head by one per transfer
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			tail  <= tail + PTR_W'(push_n);
			if (pop)
				head <= head + 1'b1;
			count <= count + CNT_W'(push_n) - CNT_W'(pop);
		end
	end

endmodule

// ==== logic/gselect_pattern_table.sv ====
// Gselect pattern table of two-bit counters with global history, four lookups and one update

`timescale 1ns/10ps

module gselect_pattern_table import bp_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int HIST_W = 2
)
(
	input  logic              clk,
	input  logic              rst,
	input  logic              en,
	input  logic              upd_valid,
	input  logic [ADDR_W-1:0] upd_pc,
	input  logic              upd_taken,
	output logic              upd_ready,
	input  logic [ADDR_W-1:0] fetch_pc0,
	input  logic [ADDR_W-1:0] fetch_pc1,
	input  logic [ADDR_W-1:0] fetch_pc2,
	input  logic [ADDR_W-1:0] fetch_pc3,
	output logic              predict_taken0,
	output logic              predict_taken1,
	output logic              predict_taken2,
	output logic              predict_taken3
);

	// Address bits sit above the history bits in every index
	localparam int TBL_IDX_W = PC_IDX_W + HIST_W;
	localparam int TBL_DEPTH = 1 << TBL_IDX_W;

	// The address must reach the top index bit
	if (ADDR_W < PC_LO + PC_IDX_W || HIST_W < 1)
	begin : g_width_check
		$error("gselect_pattern_table needs ADDR_W of at least PC_LO + PC_IDX_W");
	end

	// ==================================================
	// Table and history state
	// ==================================================

	ctr_t              table_q [TBL_DEPTH];
	logic [HIST_W-1:0] hist;

	// Lookup side
	logic [ADDR_W-1:0]    fetch_pc  [NUM_SLOTS];
	logic [TBL_IDX_W-1:0] rd_idx    [NUM_SLOTS];
	logic                 predict_q [NUM_SLOTS];

	// Update side
	logic                 upd_fire;
	logic [TBL_IDX_W-1:0] upd_idx;
	ctr_t                 ctr_cur;
	ctr_t                 ctr_next;

	// ==================================================
	// Lookups
	// ==================================================

	assign fetch_pc[0] = fetch_pc0;
	assign fetch_pc[1] = fetch_pc1;
	assign fetch_pc[2] = fetch_pc2;
	assign fetch_pc[3] = fetch_pc3;

	// Every port indexes with its own address and the shared history
	always_comb
	begin
		for (int p = 0; p < NUM_SLOTS; p++)
			rd_idx[p] = {fetch_pc[p][PC_LO +: PC_IDX_W], hist};
	end

	// Predictions see the table as it stood before this edge
	// A stalled front end gets not-taken on every port
	always_ff @(posedge clk)
	begin
		for (int p = 0; p < NUM_SLOTS; p++)
		begin
			if (rst)
				predict_q[p] <= 1'b0;
			else
				predict_q[p] <= (table_q[rd_idx[p]] >= CTR_TAKEN_MIN) && en;
		end
	end

	assign predict_taken0 = predict_q[0];
	assign predict_taken1 = predict_q[1];
	assign predict_taken2 = predict_q[2];
	assign predict_taken3 = predict_q[3];

	// ==================================================
	// Updates
	// ==================================================

	// The table accepts one outcome per enabled cycle
	assign upd_ready = en;
	assign upd_fire  = upd_valid && en;

	// Update index uses the history from before this outcome is shifted in
	assign upd_idx = {upd_pc[PC_LO +: PC_IDX_W], hist};
	assign ctr_cur = table_q[upd_idx];

	// One step toward the outcome, held at 0 and at 3
	always_comb
	begin
		ctr_next = ctr_cur;
		if (upd_taken)
		begin
			if (ctr_cur != '1)
				ctr_next = ctr_cur + 1'b1;
		end
		else
		begin
			if (ctr_cur != '0)
				ctr_next = ctr_cur - 1'b1;
		end
	end

	// Counters restart weakly not taken
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < TBL_DEPTH; i++)
				table_q[i] <= CTR_INIT;
		end
		else if (upd_fire)
		begin
			table_q[upd_idx] <= ctr_next;
		end
	end

	// Newest outcome enters at bit 0, the oldest falls off the top
	always_ff @(posedge clk)
	begin
		if (rst)
			hist <= '0;
		else if (upd_fire)
			hist <= HIST_W'({hist, upd_taken});
	end

endmodule

// ==== logic/gselect_predictor.sv ====
// Four-wide gselect branch direction predictor built from the update queue and the table

`timescale 1ns/10ps

module gselect_predictor
#(
	parameter int ADDR_W = 32,
	parameter int HIST_W = 2,
	parameter int QUEUE_DEPTH = 16
)
(
	input  logic              clk,
	input  logic              rst,
	input  logic              en,
	input  logic              commit_valid0,
	input  logic              commit_valid1,
	input  logic              commit_valid2,
	input  logic              commit_valid3,
	input  logic [ADDR_W-1:0] commit_pc0,
	input  logic [ADDR_W-1:0] commit_pc1,
	input  logic [ADDR_W-1:0] commit_pc2,
	input  logic [ADDR_W-1:0] commit_pc3,
	input  logic              commit_taken0,
	input  logic              commit_taken1,
	input  logic              commit_taken2,
	input  logic              commit_taken3,
	output logic              commit_ready,
	input  logic [ADDR_W-1:0] fetch_pc0,
	input  logic [ADDR_W-1:0] fetch_pc1,
	input  logic [ADDR_W-1:0] fetch_pc2,
	input  logic [ADDR_W-1:0] fetch_pc3,
	output logic              predict_taken0,
	output logic              predict_taken1,
	output logic              predict_taken2,
	output logic              predict_taken3
);

	// ==================================================
	// Queue to table handshake
	// ==================================================

	logic              upd_valid;
	logic [ADDR_W-1:0] upd_pc;
	logic              upd_taken;
	logic              upd_ready;

	// Resolved branches are buffered here in commit order
	branch_update_queue #(
		.ADDR_W      (ADDR_W),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) queue_i (
		.clk           (clk),
		.rst           (rst),
		.commit_valid0 (commit_valid0),
		.commit_valid1 (commit_valid1),
		.commit_valid2 (commit_valid2),
		.commit_valid3 (commit_valid3),
		.commit_pc0    (commit_pc0),
		.commit_pc1    (commit_pc1),
		.commit_pc2    (commit_pc2),
		.commit_pc3    (commit_pc3),
		.commit_taken0 (commit_taken0),
		.commit_taken1 (commit_taken1),
		.commit_taken2 (commit_taken2),
		.commit_taken3 (commit_taken3),
		.commit_ready  (commit_ready),
		.upd_valid     (upd_valid),
		.upd_pc        (upd_pc),
		.upd_taken     (upd_taken),
		.upd_ready     (upd_ready)
	);

	// The table drains the queue only while the predictor is enabled
	gselect_pattern_table #(
		.ADDR_W (ADDR_W),
		.HIST_W (HIST_W)
	) table_i (
		.clk            (clk),
		.rst            (rst),
		.en             (en),
		.upd_valid      (upd_valid),
		.upd_pc         (upd_pc),
		.upd_taken      (upd_taken),
		.upd_ready      (upd_ready),
		.fetch_pc0      (fetch_pc0),
		.fetch_pc1      (fetch_pc1),
		.fetch_pc2      (fetch_pc2),
		.fetch_pc3      (fetch_pc3),
		.predict_taken0 (predict_taken0),
		.predict_taken1 (predict_taken1),
		.predict_taken2 (predict_taken2),
		.predict_taken3 (predict_taken3)
	);

endmodule

// ==== testbench/gselect_props.sv ====
// Handshake and occupancy assertions for the branch update queue, attached by bind

`timescale 1ns/10ps

module gselect_props
#(
	parameter int ADDR_W = 32,
	parameter int QUEUE_DEPTH = 16
)
(
	input logic                         clk,
	input logic                         rst,
	input logic                         commit_valid0,
	input logic                         commit_valid1,
	input logic                         commit_valid2,
	input logic                         commit_valid3,
	input logic                         commit_ready,
	input logic                         upd_valid,
	input logic                         upd_ready,
	input logic [ADDR_W-1:0]            upd_pc,
	input logic                         upd_taken,
	input logic [$clog2(QUEUE_DEPTH):0] count
);

	// Occupancy rebuilt from the commit and drain handshakes alone
	int push_seen;
	int occupancy;

	assign push_seen = commit_ready ? (int'(commit_valid0) + int'(commit_valid1)
		+ int'(commit_valid2) + int'(commit_valid3)) : 0;

	always_ff @(posedge clk)
	begin
		if (rst)
			occupancy <= 0;
		else
			occupancy <= occupancy + push_seen - int'(upd_valid && upd_ready);
	end

	// An offered entry must have been pushed and not yet drained
	a_valid_has_entry: assert property (@(posedge clk) disable iff (rst)
		upd_valid |-> occupancy != 0)
		else $error("upd_valid is high while the update queue is empty");

	// Occupancy stays within the storage
	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		count <= QUEUE_DEPTH)
		else $error("update queue occupancy is above QUEUE_DEPTH");

	// A stalled head entry must not change under the table
	a_head_stable: assert property (@(posedge clk) disable iff (rst)
		upd_valid && !upd_ready |=> $stable(upd_pc) && $stable(upd_taken))
		else $error("head entry changed while the table was stalled");

endmodule

bind branch_update_queue gselect_props #(
	.ADDR_W      (ADDR_W),
	.QUEUE_DEPTH (QUEUE_DEPTH)
) props_i (
	.clk           (clk),
	.rst           (rst),
	.commit_valid0 (commit_valid0),
	.commit_valid1 (commit_valid1),
	.commit_valid2 (commit_valid2),
	.commit_valid3 (commit_valid3),
	.commit_ready  (commit_ready),
	.upd_valid     (upd_valid),
	.upd_ready     (upd_ready),
	.upd_pc        (upd_pc),
	.upd_taken     (upd_taken),
	.count         (count)
);

// ==== testbench/gselect_tb.sv ====
// Testbench for the gselect predictor with a stimulus table checked against a reference model

`timescale 1ns/10ps

module gselect_tb import bp_pkg::*;
();

	localparam int ADDR_W = 32;
	localparam int HIST_W = 2;
	localparam int QUEUE_DEPTH = 16;
	localparam int TBL_DEPTH = 1 << (PC_IDX_W + HIST_W);
	localparam int MAX_ROWS = 512;
	localparam int HOLD_LIMIT = 40;

	logic              clk;
	logic              rst;
	logic              en;
	logic              c_valid [NUM_SLOTS];
	logic [ADDR_W-1:0] c_pc    [NUM_SLOTS];
	logic              c_taken [NUM_SLOTS];
	logic [ADDR_W-1:0] f_pc    [NUM_SLOTS];
	logic              pred    [NUM_SLOTS];
	logic              commit_ready;

	// Stimulus table where slot s of a row uses the row address plus s times 8
	logic              row_en    [MAX_ROWS];
	logic              row_hold  [MAX_ROWS];
	logic [3:0]        row_valid [MAX_ROWS];
	logic [3:0]        row_taken [MAX_ROWS];
	logic [ADDR_W-1:0] row_cpc   [MAX_ROWS];
	logic [ADDR_W-1:0] row_fpc   [MAX_ROWS];
	int                n_rows;

	// Reference model state where each queue word is {taken, pc}
	logic [ADDR_W:0]   mq [$];
	ctr_t              m_ctr [TBL_DEPTH];
	logic [HIST_W-1:0] m_hist;
	// Expected counters and enable for the edge being checked
	ctr_t              exp_ctr [NUM_SLOTS];
	logic              exp_en;
	logic [31:0]       rng;
	int                pred_errors;
	int                ready_errors;
	int                timeouts;
	logic              timed_out;

	gselect_predictor #(
		.ADDR_W (ADDR_W), .HIST_W (HIST_W), .QUEUE_DEPTH (QUEUE_DEPTH)
	) dut_i (
		.clk (clk), .rst (rst), .en (en),
		.commit_valid0 (c_valid[0]), .commit_valid1 (c_valid[1]),
		.commit_valid2 (c_valid[2]), .commit_valid3 (c_valid[3]),
		.commit_pc0 (c_pc[0]), .commit_pc1 (c_pc[1]),
		.commit_pc2 (c_pc[2]), .commit_pc3 (c_pc[3]),
		.commit_taken0 (c_taken[0]), .commit_taken1 (c_taken[1]),
		.commit_taken2 (c_taken[2]), .commit_taken3 (c_taken[3]),
		.commit_ready (commit_ready),
		.fetch_pc0 (f_pc[0]), .fetch_pc1 (f_pc[1]),
		.fetch_pc2 (f_pc[2]), .fetch_pc3 (f_pc[3]),
		.predict_taken0 (pred[0]), .predict_taken1 (pred[1]),
		.predict_taken2 (pred[2]), .predict_taken3 (pred[3])
	);

	// Free-running 4 ns clock
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Gselect index with address bits 9:3 above the history
	function automatic int tbl_index(input logic [ADDR_W-1:0] pc, input logic [HIST_W-1:0] h);
		return int'({pc[PC_LO +: PC_IDX_W], h});
	endfunction

	task automatic add_row(input logic e, input logic h, input logic [3:0] v,
		input logic [3:0] t, input logic [ADDR_W-1:0] cpc, input logic [ADDR_W-1:0] fpc);
		row_en[n_rows]    = e;
		row_hold[n_rows]  = h;
		row_valid[n_rows] = v;
		row_taken[n_rows] = t;
		row_cpc[n_rows]   = cpc;
		row_fpc[n_rows]   = fpc;
		n_rows++;
	endtask

	// Enabled cycles with no commits give the queue time to drain
	task automatic add_idle(input int n, input logic [ADDR_W-1:0] fpc);
		for (int i = 0; i < n; i++)
			add_row(1'b1, 1'b0, 4'b0000, 4'b0000, '0, fpc);
	endtask

	// ==================================================
	// Scenario rows, then the random mix
	// ==================================================
	task automatic build_table();
		add_idle(3, 32'h40);
		// Train one address up to strongly taken and back down
		for (int i = 0; i < 4; i++)
			add_row(1'b1, 1'b1, 4'b0001, 4'b0001, 32'h40, 32'h40);
		add_idle(2, 32'h40);
		for (int i = 0; i < 4; i++)
			add_row(1'b1, 1'b1, 4'b0001, 4'b0000, 32'h40, 32'h40);
		add_idle(2, 32'h40);
		// Same fetch address under history 11 and then under history 00
		add_row(1'b1, 1'b1, 4'b0011, 4'b0011, 32'h100, 32'h40);
		add_row(1'b1, 1'b1, 4'b0001, 4'b0001, 32'h40, 32'h40);
		add_row(1'b1, 1'b1, 4'b0001, 4'b0001, 32'h40, 32'h40);
		add_idle(3, 32'h40);
		add_row(1'b1, 1'b1, 4'b0011, 4'b0000, 32'h100, 32'h40);
		add_idle(3, 32'h40);
		// Sparse slot groups drain lower slot first
		add_row(1'b1, 1'b1, 4'b0011, 4'b0010, 32'h40, 32'h40);
		add_row(1'b1, 1'b1, 4'b1010, 4'b1000, 32'h40, 32'h40);
		add_idle(4, 32'h38);
		// Fill the queue with the table stalled, then release it
		for (int i = 0; i < 4; i++)
			add_row(1'b0, 1'b1, 4'b1111, 4'b0101 << (i % 2), 32'h40, 32'h40);
		add_row(1'b0, 1'b0, 4'b0000, 4'b0000, '0, 32'h40);
		add_row(1'b0, 1'b1, 4'b1111, 4'b1111, 32'h48, 32'h40);
		add_idle(20, 32'h40);
		// Random enable, slots, outcomes and addresses over a small address window
		for (int k = 0; k < 300; k++)
		begin
			rng = xorshift32(rng);
			add_row(rng[1] | rng[2], rng[11:8] != 4'b0000, rng[11:8], rng[15:12],
				32'h1000 + {rng[19:16], 3'b000}, 32'h1000 + {rng[23:20], 3'b000});
		end
	endtask

	task automatic apply_row(input int r);
		en = row_en[r];
		for (int s = 0; s < NUM_SLOTS; s++)
		begin
			c_valid[s] = row_valid[r][s];
			c_taken[s] = row_taken[r][s];
			c_pc[s]    = row_cpc[r] + ADDR_W'(s * 8);
			f_pc[s]    = row_fpc[r] + ADDR_W'(s * 8);
		end
	endtask

	// Advances the model by the coming edge; accepted tells if the commit group goes in
	task automatic model_step(output logic accepted);
		logic [ADDR_W:0] e;
		int              i;
		accepted = (QUEUE_DEPTH - mq.size()) >= NUM_SLOTS;
		// Lookups read the table and history from before the edge
		for (int p = 0; p < NUM_SLOTS; p++)
			exp_ctr[p] = m_ctr[tbl_index(f_pc[p], m_hist)];
		exp_en = en;
		// Only entries from earlier edges can drain
		if (en && mq.size() > 0)
		begin
			e = mq.pop_front();
			i = tbl_index(e[ADDR_W-1:0], m_hist);
			if (e[ADDR_W] && m_ctr[i] != 2'd3)
				m_ctr[i] = m_ctr[i] + 2'd1;
			else if (!e[ADDR_W] && m_ctr[i] != 2'd0)
				m_ctr[i] = m_ctr[i] - 2'd1;
			m_hist = HIST_W'({m_hist, e[ADDR_W]});
		end
		// Accepted slots join the model queue in slot order
		if (accepted)
		begin
			for (int s = 0; s < NUM_SLOTS; s++)
				if (c_valid[s])
					mq.push_back({c_taken[s], c_pc[s]});
		end
	endtask

	task automatic check_prediction(input string name, input logic actual, input ctr_t ctr,
		input logic en_s);
		logic expected;
		expected = (ctr >= CTR_TAKEN_MIN) && en_s;
		if (actual !== expected)
		begin
			$display("** Error @ %0d ns: %s is %0b, expected %0b",
				$time, name, actual, expected);
			pred_errors++;
		end
	endtask

	task automatic check_ready(input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("** Error @ %0d ns: commit_ready is %0b, expected %0b",
				$time, actual, expected);
			ready_errors++;
		end
	endtask

	// The ready expectation reflects the model queue after the edge just taken
	task automatic compare_outputs();
		for (int p = 0; p < NUM_SLOTS; p++)
			check_prediction($sformatf("predict_taken%0d", p), pred[p], exp_ctr[p], exp_en);
		check_ready(commit_ready, (QUEUE_DEPTH - mq.size()) >= NUM_SLOTS);
	endtask

	initial
	begin
		logic accepted;
		int   waits;
		n_rows       = 0;
		rng          = 32'h4ddfeb9d;
		pred_errors  = 0;
		ready_errors = 0;
		timeouts     = 0;
		timed_out    = 1'b0;
		m_hist       = '0;
		for (int i = 0; i < TBL_DEPTH; i++)
			m_ctr[i] = CTR_INIT;
		rst = 1'b1;
		build_table();
		apply_row(0);
		en = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		// Reset leaves every counter weakly not taken and the queue empty
		for (int p = 0; p < NUM_SLOTS; p++)
			check_prediction($sformatf("predict_taken%0d", p), pred[p], CTR_INIT, 1'b1);
		check_ready(commit_ready, 1'b1);
		for (int r = 0; r < n_rows && !timed_out; r++)
		begin
			apply_row(r);
			waits = 0;
			// A held group stays on the commit side with the table enabled until it is taken
			do
			begin
				model_step(accepted);
				@(posedge clk);
				#1;
				compare_outputs();
				if (row_hold[r] && !accepted)
				begin
					waits++;
					en = 1'b1;
					if (waits > HOLD_LIMIT)
					begin
						$display("Timeout: commit group of row %0d was never accepted", r);
						timeouts++;
						timed_out = 1'b1;
					end
				end
			end
			while (row_hold[r] && !accepted && !timed_out);
		end
		$display("Error counts: prediction %0d, ready %0d, timeout %0d",
			pred_errors, ready_errors, timeouts);
		if (pred_errors + ready_errors + timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== sources.f ====
logic/bp_pkg.sv
logic/branch_update_queue.sv
logic/gselect_pattern_table.sv
logic/gselect_predictor.sv
testbench/gselect_props.sv
testbench/gselect_tb.sv

// ==== Bender.yml ====
package:
  name: gselect_predictor

sources:
  - logic/bp_pkg.sv
  - logic/branch_update_queue.sv
  - logic/gselect_pattern_table.sv
  - logic/gselect_predictor.sv
  - target: test
    files:
      - testbench/gselect_props.sv
      - testbench/gselect_tb.sv
